//--- Makefile
# Verilator simulation of the multiply/divide unit.
VERILATOR ?= verilator
TOP       ?= tb_muldiv
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "RESULT: FAIL" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- div_iter.sv
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module div_iter import muldiv_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst_n,
  input  logic  i_start,
  input  logic  i_word,
  input  logic  i_signed,
  input  xlen_t i_dividend,
  input  xlen_t i_divisor,
  output logic  o_busy,
  output logic  o_end_valid,
  input  logic  i_end_ready,
  output xlen_t o_quotient,
  output xlen_t o_remainder
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Iteration control
  cnt_t cnt;

  assign o_busy = (|cnt) | o_end_valid;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cnt <= '0;
    end else if (i_start) begin
      cnt <= i_word ? cnt_t'(`MD_WLEN - 1) : cnt_t'(`MD_XLEN - 1);  // 31 or 63.
    end else if (|cnt) begin
      cnt <= cnt - 1'b1;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_end_valid <= 1'b0;
    end else if (cnt == cnt_t'(1)) begin
      o_end_valid <= 1'b1;  // Last bit resolves combinationally.
    end else if (i_end_ready) begin
      o_end_valid <= 1'b0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operand preparation
  xlen_t dvd_ext, dvs_ext, dvd_abs, dvs_abs;
  logic  dvd_neg, dvs_neg;

  // Unsigned W forms zero-extend, signed ones sign-extend.
  assign dvd_ext = i_word ? {{(`MD_XLEN - `MD_WLEN){i_signed & i_dividend[`MD_WLEN-1]}},
                             i_dividend[`MD_WLEN-1:0]} : i_dividend;
  assign dvs_ext = i_word ? {{(`MD_XLEN - `MD_WLEN){i_signed & i_divisor[`MD_WLEN-1]}},
                             i_divisor[`MD_WLEN-1:0]} : i_divisor;

  assign dvd_neg = i_signed & dvd_ext[`MD_XLEN-1];
  assign dvs_neg = i_signed & dvs_ext[`MD_XLEN-1];
  assign dvd_abs = dvd_neg ? (~dvd_ext + 1'b1) : dvd_ext;
  assign dvs_abs = dvs_neg ? (~dvs_ext + 1'b1) : dvs_ext;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Restoring iteration
  dxlen_t            rem_r, rem_nxt, rem_shr, low_mask;
  xlen_t             dvs_r, quo_r, quo_nxt;
  logic [`MD_XLEN:0] trial;
  logic              fits;
  logic              dvd_neg_r, dvs_neg_r, zero_r;

  assign rem_shr  = rem_r >> cnt;
  assign trial    = rem_shr[`MD_XLEN:0] - {1'b0, dvs_r};
  assign fits     = ~trial[`MD_XLEN];                  // No borrow.
  assign low_mask = (dxlen_t'(1) << cnt) - 1'b1;       // Bits not yet shifted in.
  assign rem_nxt  = fits ? ((dxlen_t'(trial) << cnt) | (rem_r & low_mask)) : rem_r;

  always_comb begin
    quo_nxt      = quo_r;
    quo_nxt[cnt] = fits;
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      rem_r     <= {{`MD_XLEN{1'b0}}, dvd_abs};
      dvs_r     <= dvs_abs;
      quo_r     <= '0;
      dvd_neg_r <= dvd_neg;  // Signs held for the whole run.
      dvs_neg_r <= dvs_neg;
      zero_r    <= ~|dvs_ext;
    end else if (|cnt) begin
      rem_r <= rem_nxt;
      quo_r <= quo_nxt;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Result with RISC-V sign rules
  xlen_t quo_mag, rem_mag, quo_fix, rem_fix;

  assign quo_mag = quo_nxt;
  assign rem_mag = rem_nxt[`MD_XLEN-1:0];
  assign quo_fix = zero_r ? '1 :                          // Divide by zero.
                   (dvd_neg_r ^ dvs_neg_r) ? (~quo_mag + 1'b1) : quo_mag;
  assign rem_fix = dvd_neg_r ? (~rem_mag + 1'b1) : rem_mag; // Equals dividend on zero.

  assign o_quotient  = o_end_valid ? quo_fix : '0;
  assign o_remainder = o_end_valid ? rem_fix : '0;

endmodule

//--- mul_iter.sv
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module mul_iter import muldiv_pkg::*; (
  input  logic   i_clk,
  input  logic   i_rst_n,
  input  logic   i_start,
  input  logic   i_word,
  input  logic   i_a_signed,
  input  logic   i_b_signed,
  input  xlen_t  i_a,
  input  xlen_t  i_b,
  output logic   o_busy,
  output logic   o_end_valid,
  input  logic   i_end_ready,
  output dxlen_t o_product
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Iteration control
  cnt_t cnt;

  assign o_busy = (|cnt) | o_end_valid;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cnt <= '0;
    end else if (i_start) begin
      cnt <= i_word ? cnt_t'(`MD_WLEN - 1) : cnt_t'(`MD_XLEN - 1);  // 31 or 63.
    end else if (|cnt) begin
      cnt <= cnt - 1'b1;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_end_valid <= 1'b0;
    end else if (cnt == cnt_t'(1)) begin
      o_end_valid <= 1'b1;
    end else if (i_end_ready) begin
      o_end_valid <= 1'b0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operand magnitudes
  xlen_t a_ext, b_ext, a_abs, b_abs;
  logic  a_neg, b_neg;

  assign a_ext = i_word ? {{(`MD_XLEN - `MD_WLEN){i_a_signed & i_a[`MD_WLEN-1]}},
                           i_a[`MD_WLEN-1:0]} : i_a;
  assign b_ext = i_word ? {{(`MD_XLEN - `MD_WLEN){i_b_signed & i_b[`MD_WLEN-1]}},
                           i_b[`MD_WLEN-1:0]} : i_b;

  assign a_neg = i_a_signed & a_ext[`MD_XLEN-1];
  assign b_neg = i_b_signed & b_ext[`MD_XLEN-1];
  assign a_abs = a_neg ? (~a_ext + 1'b1) : a_ext;
  assign b_abs = b_neg ? (~b_ext + 1'b1) : b_ext;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Shift-add datapath
  dxlen_t mcand_r, acc_r, acc_nxt;
  xlen_t  mplier_r;
  logic   neg_r;

  // One multiplier bit per cycle, LSB first.
  assign acc_nxt = mplier_r[0] ? (acc_r + mcand_r) : acc_r;

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      mcand_r  <= dxlen_t'(a_abs);
      mplier_r <= b_abs;
      acc_r    <= '0;
      neg_r    <= a_neg ^ b_neg;  // Product sign.
    end else if (|cnt) begin
      acc_r    <= acc_nxt;
      mcand_r  <= mcand_r << 1;
      mplier_r <= mplier_r >> 1;
    end
  end

  assign o_product = !o_end_valid ? '0 :
                     neg_r ? (~acc_nxt + 1'b1) : acc_nxt;  // Final bit added here.

endmodule

//--- muldiv_consts.svh
`ifndef MULDIV_CONSTS_SVH
`define MULDIV_CONSTS_SVH

// Datapath widths of the RV64 M unit.
`define MD_XLEN   64
`define MD_WLEN   32
`define MD_CNT_W  6

// funct3 codes of the M extension.
`define MD_OP_MUL     3'b000
`define MD_OP_MULH    3'b001
`define MD_OP_MULHSU  3'b010
`define MD_OP_MULHU   3'b011
`define MD_OP_DIV     3'b100
`define MD_OP_DIVU    3'b101
`define MD_OP_REM     3'b110
`define MD_OP_REMU    3'b111

`endif

//--- muldiv_ctrl.sv
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module muldiv_ctrl import muldiv_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  muldiv_req_t i_req,
  input  logic        i_req_valid,
  output logic        o_req_ready,
  input  muldiv_ctl_t i_ctl,
  output logic        o_mul_start,
  output logic        o_div_start,
  output logic        o_word,
  output logic        o_a_signed,
  output logic        o_b_signed,
  output xlen_t       o_a,
  output xlen_t       o_b,
  input  logic        i_mul_valid,
  input  dxlen_t      i_product,
  input  logic        i_div_valid,
  input  xlen_t       i_quotient,
  input  xlen_t       i_remainder,
  output logic        o_end_ready,
  output xlen_t       o_rsp_data,
  output logic        o_rsp_valid,
  input  logic        i_rsp_ready
);

  ctrl_state_e state, state_nxt;
  muldiv_ctl_t ctl_r;
  xlen_t       a_r, b_r, rsp_r;
  xlen_t       sel, sel_fmt;
  logic        req_fire, blk_valid;
  logic        mul_start_r, div_start_r;

  assign o_req_ready = (state == CTRL_IDLE);
  assign req_fire    = i_req_valid & o_req_ready;
  assign blk_valid   = ctl_r.is_div ? i_div_valid : i_mul_valid;
  assign o_end_ready = (state == CTRL_RUN) & blk_valid;  // Same-cycle accept.
  assign o_rsp_valid = (state == CTRL_RESP);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sequencer FSM
  always_comb begin
    state_nxt = state;
    case (state)
      CTRL_IDLE: if (req_fire)    state_nxt = CTRL_RUN;
      CTRL_RUN:  if (blk_valid)   state_nxt = CTRL_RESP;
      CTRL_RESP: if (i_rsp_ready) state_nxt = CTRL_IDLE;
      default:                    state_nxt = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state       <= CTRL_IDLE;
      ctl_r       <= '0;
      mul_start_r <= 1'b0;
      div_start_r <= 1'b0;
    end else begin
      state       <= state_nxt;
      mul_start_r <= req_fire & ~i_ctl.is_div;  // One-cycle pulse.
      div_start_r <= req_fire & i_ctl.is_div;
      if (req_fire) begin
        ctl_r <= i_ctl;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operands and response data
  always_comb begin
    if (ctl_r.is_div) begin
      sel = ctl_r.sel_rem ? i_remainder : i_quotient;
    end else begin
      sel = ctl_r.sel_hi ? i_product[2*`MD_XLEN-1:`MD_XLEN] : i_product[`MD_XLEN-1:0];
    end
  end

  // W results are sign-extended from bit 31.
  assign sel_fmt = ctl_r.word ? {{(`MD_XLEN - `MD_WLEN){sel[`MD_WLEN-1]}}, sel[`MD_WLEN-1:0]}
                              : sel;

  always_ff @(posedge i_clk) begin
    if (req_fire) begin
      a_r <= i_req.rs1;
      b_r <= i_req.rs2;
    end
    if (o_end_ready) begin
      rsp_r <= sel_fmt;  // Held until the response transfers.
    end
  end

  assign o_mul_start = mul_start_r;
  assign o_div_start = div_start_r;
  assign o_word      = ctl_r.word;
  assign o_a_signed  = ctl_r.a_signed;
  assign o_b_signed  = ctl_r.b_signed;
  assign o_a         = a_r;
  assign o_b         = b_r;
  assign o_rsp_data  = rsp_r;

endmodule

//--- muldiv_decode.sv
`timescale 1ns/1ps

module muldiv_decode import muldiv_pkg::*; (
  input  muldiv_op_e  i_op,
  input  logic        i_word,
  output muldiv_ctl_t o_ctl
);

  always_comb begin
    o_ctl      = '0;
    o_ctl.word = i_word;
    case (i_op)
      OP_MUL: begin
        o_ctl.sel_hi = 1'b0;  // Low half is sign independent.
      end
      OP_MULH: begin
        o_ctl.a_signed = 1'b1;
        o_ctl.b_signed = 1'b1;
        o_ctl.sel_hi   = 1'b1;
      end
      OP_MULHSU: begin
        o_ctl.a_signed = 1'b1;  // Only rs1 signed.
        o_ctl.sel_hi   = 1'b1;
      end
      OP_MULHU: begin
        o_ctl.sel_hi = 1'b1;
      end
      OP_DIV: begin
        o_ctl.is_div   = 1'b1;
        o_ctl.a_signed = 1'b1;
        o_ctl.b_signed = 1'b1;
      end
      OP_DIVU: begin
        o_ctl.is_div = 1'b1;
      end
      OP_REM: begin
        o_ctl.is_div   = 1'b1;
        o_ctl.a_signed = 1'b1;
        o_ctl.b_signed = 1'b1;
        o_ctl.sel_rem  = 1'b1;
      end
      OP_REMU: begin
        o_ctl.is_div  = 1'b1;
        o_ctl.sel_rem = 1'b1;
      end
      default: begin
        o_ctl.is_div = 1'b0;
      end
    endcase
  end

endmodule

//--- muldiv_pkg.sv
`include "muldiv_consts.svh"

package muldiv_pkg;

  typedef logic [`MD_XLEN-1:0]   xlen_t;   // Operand or result.
  typedef logic [2*`MD_XLEN-1:0] dxlen_t;  // Full product, partial remainder.
  typedef logic [`MD_CNT_W-1:0]  cnt_t;    // Iteration count.

  typedef enum logic [2:0] {
    OP_MUL    = `MD_OP_MUL,
    OP_MULH   = `MD_OP_MULH,
    OP_MULHSU = `MD_OP_MULHSU,
    OP_MULHU  = `MD_OP_MULHU,
    OP_DIV    = `MD_OP_DIV,
    OP_DIVU   = `MD_OP_DIVU,
    OP_REM    = `MD_OP_REM,
    OP_REMU   = `MD_OP_REMU
  } muldiv_op_e;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_RUN,
    CTRL_RESP
  } ctrl_state_e;

  typedef struct packed {
    muldiv_op_e op;
    logic       word;   // W form, 32-bit operation.
    xlen_t      rs1;
    xlen_t      rs2;
  } muldiv_req_t;

  typedef struct packed {
    logic is_div;     // Divider instead of multiplier.
    logic a_signed;
    logic b_signed;
    logic sel_hi;     // Upper product half.
    logic sel_rem;    // Remainder instead of quotient.
    logic word;
  } muldiv_ctl_t;

endpackage

//--- muldiv_top.sv
`timescale 1ns/1ps

module muldiv_top import muldiv_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  muldiv_req_t i_req,
  input  logic        i_req_valid,
  output logic        o_req_ready,
  output xlen_t       o_rsp_data,
  output logic        o_rsp_valid,
  input  logic        i_rsp_ready
);

  muldiv_ctl_t ctl;
  logic        mul_start, div_start, word, a_signed, b_signed;
  logic        mul_valid, div_valid, end_ready;
  xlen_t       op_a, op_b, quotient, remainder;
  dxlen_t      product;

  muldiv_decode u_decode (
    .i_op  (i_req.op),
    .i_word(i_req.word),
    .o_ctl (ctl)
  );

  muldiv_ctrl u_ctrl (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_req      (i_req),
    .i_req_valid(i_req_valid),
    .o_req_ready(o_req_ready),
    .i_ctl      (ctl),
    .o_mul_start(mul_start),
    .o_div_start(div_start),
    .o_word     (word),
    .o_a_signed (a_signed),
    .o_b_signed (b_signed),
    .o_a        (op_a),
    .o_b        (op_b),
    .i_mul_valid(mul_valid),
    .i_product  (product),
    .i_div_valid(div_valid),
    .i_quotient (quotient),
    .i_remainder(remainder),
    .o_end_ready(end_ready),
    .o_rsp_data (o_rsp_data),
    .o_rsp_valid(o_rsp_valid),
    .i_rsp_ready(i_rsp_ready)
  );

  mul_iter u_mul (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_start    (mul_start),
    .i_word     (word),
    .i_a_signed (a_signed),
    .i_b_signed (b_signed),
    .i_a        (op_a),
    .i_b        (op_b),
    .o_busy     (),
    .o_end_valid(mul_valid),
    .i_end_ready(end_ready),
    .o_product  (product)
  );

  // Signed divide sets both flags, so the rs1 flag drives the divider.
  div_iter u_div (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_start    (div_start),
    .i_word     (word),
    .i_signed   (a_signed),
    .i_dividend (op_a),
    .i_divisor  (op_b),
    .o_busy     (),
    .o_end_valid(div_valid),
    .i_end_ready(end_ready),
    .o_quotient (quotient),
    .o_remainder(remainder)
  );

endmodule

//--- src.f
+incdir+.
muldiv_pkg.sv
muldiv_decode.sv
div_iter.sv
mul_iter.sv
muldiv_ctrl.sv
muldiv_top.sv
tb_muldiv.sv

//--- tb_muldiv.sv
`timescale 1ns/1ps
`include "muldiv_consts.svh"

module tb_muldiv import muldiv_pkg::*; ();

  localparam int N_PER_OP    = 10;
  localparam int N_REQ       = 13 * N_PER_OP + 10;  // Full, word and corner requests.
  localparam int CYCLE_LIMIT = N_REQ * 80 + 200;

  logic        i_clk;
  logic        i_rst_n;
  muldiv_req_t i_req;
  logic        i_req_valid;
  logic        o_req_ready;
  xlen_t       o_rsp_data;
  logic        o_rsp_valid;
  logic        i_rsp_ready;

  xlen_t       exp_q[$];           // Expected results in request order.
  xlen_t       exp_head  = '0;
  int          exp_cnt   = 0;
  int          exp_lat   = 0;
  int          lat       = 0;      // Cycles since the last accepted request.
  int          cycles    = 0;
  int          errors    = 0;
  int          n_sent    = 0;
  int          n_acc     = 0;
  int          n_rsp     = 0;
  logic        in_flight = 1'b0;
  logic        stall_on  = 1'b0;
  logic [31:0] stim_seed = 32'd50559;
  logic [31:0] rdy_seed  = 32'd50559 ^ 32'h0f0f_0f0f;

  muldiv_top dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;  // 8 ns period.
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus and reference model
  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw_operand(output xlen_t v);
    logic [31:0] sel;
    logic [31:0] hi;
    stim_seed = lcg(stim_seed);
    sel       = stim_seed;
    stim_seed = lcg(stim_seed);
    hi        = stim_seed;
    stim_seed = lcg(stim_seed);
    case (sel[31:28])
      4'd0:    v = '0;
      4'd1:    v = 64'd1;
      4'd2:    v = '1;
      4'd3:    v = {1'b1, 63'd0};                          // Most negative.
      4'd4:    v = {{48{hi[31]}}, stim_seed[31:16]};       // Small signed value.
      default: v = {hi, stim_seed};
    endcase
  endtask

  function automatic xlen_t ref_result(input muldiv_op_e op, input logic word,
                                       input xlen_t a, input xlen_t b);
    dxlen_t ua, ub, prod, quo, rem;
    logic   a_sgn, b_sgn;
    xlen_t  res;
    a_sgn = op inside {OP_MULH, OP_MULHSU, OP_DIV, OP_REM};
    b_sgn = op inside {OP_MULH, OP_DIV, OP_REM};
    if (word) begin
      ua = a_sgn ? {{96{a[31]}}, a[31:0]} : {96'd0, a[31:0]};
      ub = b_sgn ? {{96{b[31]}}, b[31:0]} : {96'd0, b[31:0]};
    end else begin
      ua = a_sgn ? {{64{a[63]}}, a} : {64'd0, a};
      ub = b_sgn ? {{64{b[63]}}, b} : {64'd0, b};
    end
    prod = ua * ub;  // Exact in 128 bits for either signedness.
    if (ub == '0) begin
      quo = '1;
      rem = ua;
    end else if (a_sgn) begin
      quo = $signed(ua) / $signed(ub);  // Truncates toward zero.
      rem = $signed(ua) % $signed(ub);
    end else begin
      quo = ua / ub;
      rem = ua % ub;
    end
    case (op)
      OP_MUL:                       res = prod[63:0];
      OP_MULH, OP_MULHSU, OP_MULHU: res = prod[127:64];
      OP_DIV, OP_DIVU:              res = quo[63:0];
      default:                      res = rem[63:0];
    endcase
    if (word) begin
      res = {{32{res[31]}}, res[31:0]};
    end
    return res;
  endfunction

  task automatic refresh_head();
    exp_cnt  = exp_q.size();
    exp_head = (exp_cnt != 0) ? exp_q[0] : '0;
  endtask

  // Called 1 ns after a rising edge; returns at the same phase.
  task automatic send_req(input muldiv_op_e op, input logic word,
                          input xlen_t a, input xlen_t b);
    while (!o_req_ready) begin
      @(posedge i_clk);
      #1;
    end
    i_req.op    = op;
    i_req.word  = word;
    i_req.rs1   = a;
    i_req.rs2   = b;
    i_req_valid = 1'b1;
    exp_lat     = word ? 33 : 65;
    exp_q.push_back(ref_result(op, word, a, b));
    refresh_head();
    n_sent++;
    @(posedge i_clk);
    #1;
    i_req_valid = 1'b0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Monitors
  always @(posedge i_clk) begin
    if (i_rst_n && i_req_valid && o_req_ready) begin
      in_flight <= 1'b1;
      lat       <= 0;
      n_acc     <= n_acc + 1;
    end else if (in_flight) begin
      lat <= lat + 1;
    end
    if (i_rst_n && o_rsp_valid && i_rsp_ready) begin
      in_flight <= 1'b0;
      n_rsp     <= n_rsp + 1;
      if (exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      refresh_head();
    end
  end

  initial begin : ready_gen
    logic [3:0] hold;
    i_rsp_ready = 1'b0;
    hold        = '0;
    forever begin
      @(posedge i_clk);
      #1;
      if (!stall_on) begin
        i_rsp_ready = 1'b1;
      end else if (hold != 0) begin
        hold = hold - 4'd1;
      end else begin
        rdy_seed    = lcg(rdy_seed);
        i_rsp_ready = ~i_rsp_ready;
        hold        = i_rsp_ready ? {2'b00, rdy_seed[17:16]} : rdy_seed[19:16];
      end
    end
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run still busy after %0d cycles, %0d of %0d responses seen",
               cycles, n_rsp, n_sent);
      $display("Summary: %0d requests, %0d responses, %0d errors", n_acc, n_rsp, errors);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  idle_after_reset: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (n_acc == 0) |-> (o_req_ready && !o_rsp_valid))
    else begin
      errors++;
      $display("ERROR @%0t: unit not idle after reset", $time);
    end

  rsp_data_match: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_rsp_valid && i_rsp_ready) |-> (exp_cnt != 0 && o_rsp_data == exp_head))
    else begin
      errors++;
      $display("ERROR @%0t: response %h, expected %h (%0d pending)", $time,
               $sampled(o_rsp_data), $sampled(exp_head), $sampled(exp_cnt));
    end

  rsp_hold_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_rsp_valid && !i_rsp_ready) |=> (o_rsp_valid && $stable(o_rsp_data)))
    else begin
      errors++;
      $display("ERROR @%0t: stalled response dropped or changed", $time);
    end

  req_blocked: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      in_flight |-> !o_req_ready)
    else begin
      errors++;
      $display("ERROR @%0t: request ready while a result is outstanding", $time);
    end

  rsp_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $rose(o_rsp_valid) |-> (lat == exp_lat))
    else begin
      errors++;
      $display("ERROR @%0t: response after %0d cycles, expected %0d", $time,
               $sampled(lat), $sampled(exp_lat));
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  initial begin : main_seq
    xlen_t      a;
    xlen_t      b;
    muldiv_op_e word_ops [5];
    word_ops    = '{OP_MUL, OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    i_rst_n     = 1'b0;
    i_req       = '0;
    i_req_valid = 1'b0;
    repeat (3) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    @(posedge i_clk);
    #1;
    for (int k = 0; k < 8; k++) begin
      for (int n = 0; n < N_PER_OP; n++) begin
        draw_operand(a);
        draw_operand(b);
        send_req(muldiv_op_e'(k[2:0]), 1'b0, a, b);
      end
    end
    stall_on = 1'b1;  // Random back-pressure from here on.
    send_req(OP_DIV,    1'b0, 64'h8000_0000_0000_0000, '1);
    send_req(OP_REM,    1'b0, 64'h8000_0000_0000_0000, '1);
    send_req(OP_DIV,    1'b0, 64'hfedc_ba98_7654_3210, '0);
    send_req(OP_DIVU,   1'b0, 64'hfedc_ba98_7654_3210, '0);
    send_req(OP_REM,    1'b0, 64'hfedc_ba98_7654_3210, '0);
    send_req(OP_REMU,   1'b0, 64'h0123_4567_89ab_cdef, '0);
    send_req(OP_DIV,    1'b1, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);
    send_req(OP_REM,    1'b1, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);
    send_req(OP_DIVU,   1'b1, 64'h5555_0000_9abc_def0, 64'habcd_0000_0000_0000);
    send_req(OP_MULHSU, 1'b0, '1, '1);
    for (int k = 0; k < 5; k++) begin
      for (int n = 0; n < N_PER_OP; n++) begin
        draw_operand(a);
        draw_operand(b);
        send_req(word_ops[k], 1'b1, a, b);
      end
    end
    while (n_rsp < n_sent) begin
      @(posedge i_clk);
      #1;
    end
    repeat (4) @(posedge i_clk);
    $display("Summary: %0d requests, %0d responses, %0d errors", n_acc, n_rsp, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
